//--- logic/axi_pkg.sv
package axi_pkg;

  // read address channel field types
  typedef logic [7:0] axi_len_t;
  typedef logic [2:0] axi_size_t;
  typedef logic [1:0] axi_burst_t;
  typedef logic [3:0] axi_cache_t;

  // incrementing burst, the only type this port issues
  localparam axi_burst_t burst_incr = 2'b01;

  // bufferable and modifiable, the value the memory controllers accept
  localparam axi_cache_t cache_modifiable = 4'b0011;

endpackage

//--- logic/mmap_pkg.sv
package mmap_pkg;

  // bus widths of the memory port
  localparam int addr_width = 64;
  localparam int data_width = 512;

  // log2 of bytes per data word, also the AXI beat size
  localparam int data_bytes_log = $clog2(data_width / 8);

  // byte address, or element index before translation
  typedef logic [addr_width-1:0] addr_t;

  // one data word as moved on the R channel
  typedef logic [data_width-1:0] data_t;

  // one inferred burst
  // len holds the beat count minus one, as on arlen
  typedef struct packed {
    addr_t              addr;
    axi_pkg::axi_len_t  len;
  } burst_req_t;

  // counts idle input cycles while a burst is open
  typedef logic [3:0] wait_t;

  // sizes used when the top level is not overridden
  localparam int default_buffer_depth  = 32;
  localparam int default_max_wait_time = 3;
  localparam int default_max_burst_len = 15;

endpackage

//--- logic/mmap_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module mmap_fifo #(
  parameter type payload_t = mmap_pkg::data_t,
  parameter int  depth     = mmap_pkg::default_buffer_depth
) (
  input  logic     clk,
  input  logic     reset,
  input  payload_t din,
  input  logic     write,
  output logic     full_n,
  output payload_t dout,
  input  logic     read,
  output logic     not_empty
);

  localparam int ptr_width   = (depth > 1) ? $clog2(depth) : 1;
  localparam int count_width = $clog2(depth + 1);

  payload_t               mem [0:depth-1];
  logic [ptr_width-1:0]   wr_ptr;
  logic [ptr_width-1:0]   rd_ptr;
  logic [ptr_width-1:0]   rd_ptr_next;
  logic [count_width-1:0] count;
  logic [count_width-1:0] count_next;
  logic                   do_write;
  logic                   do_read;
  logic                   bypass;

  // pointer advance with wrap for any depth
  function automatic logic [ptr_width-1:0] ptr_inc(input logic [ptr_width-1:0] ptr);
    logic [ptr_width-1:0] nxt;
    if (ptr == ptr_width'(depth - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  assign full_n = (count != count_width'(depth));

  always_comb begin
    do_write    = write && full_n;
    do_read     = read && not_empty;
    rd_ptr_next = do_read ? ptr_inc(rd_ptr) : rd_ptr;
    count_next  = count + count_width'(do_write) - count_width'(do_read);
    // new entry becomes the head when nothing older remains
    bypass      = do_write && (count == count_width'(do_read));
  end

  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      not_empty <= 1'b0;
    end else begin
      if (do_write) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      rd_ptr    <= rd_ptr_next;
      count     <= count_next;
      not_empty <= (count_next != '0);
    end
  end

  // registered head, refilled from the array or taken straight from din
  always_ff @(posedge clk) begin
    if (bypass) begin
      dout <= din;
    end else begin
      dout <= mem[rd_ptr_next];
    end
  end

endmodule

`default_nettype wire

//--- logic/burst_detector.sv
`timescale 1ns/10ps
`default_nettype none

module burst_detector #(
  parameter int max_wait_time = mmap_pkg::default_max_wait_time,
  parameter int max_burst_len = mmap_pkg::default_max_burst_len
) (
  input  logic                clk,
  input  logic                reset,
  input  mmap_pkg::addr_t     offset,
  input  mmap_pkg::addr_t     index,
  input  logic                index_valid,
  output logic                pop,
  output mmap_pkg::burst_req_t burst,
  output logic                burst_write,
  input  logic                burst_full_n
);

  import mmap_pkg::*;
  import axi_pkg::*;

  // one bit wider than arlen so max_burst_len + 1 fits
  localparam int count_width = $bits(axi_len_t) + 1;

  logic                   open;
  addr_t                  start_idx;
  logic [count_width-1:0] count;
  wait_t                  wait_cnt;
  logic                   burst_valid;
  logic                   can_emit;
  logic                   match;
  logic                   full;
  logic                   expired;
  logic                   close;
  logic                   emit;

  always_comb begin
    // output register free now or drained this cycle
    can_emit = !burst_valid || burst_full_n;
    match    = (index == start_idx + addr_t'(count));
    full     = (count == count_width'(max_burst_len + 1));
    expired  = (wait_cnt >= wait_t'(max_wait_time));
    close    = open && (full || expired || (index_valid && !match));
    emit     = close && can_emit;
    // a closing burst stalls the input until it can be handed off
    pop      = index_valid && (!close || can_emit);
  end

  assign burst_write = burst_valid && burst_full_n;

  always_ff @(posedge clk) begin
    if (reset) begin
      open        <= 1'b0;
      count       <= '0;
      wait_cnt    <= '0;
      burst_valid <= 1'b0;
    end else begin
      if (emit) begin
        burst_valid <= 1'b1;
      end else if (burst_full_n) begin
        burst_valid <= 1'b0;
      end

      if (pop) begin
        open     <= 1'b1;
        wait_cnt <= '0;
        // extend the open burst, or start a fresh one
        if (open && !close) begin
          count <= count + 1'b1;
        end else begin
          count <= count_width'(1);
        end
      end else if (emit) begin
        open     <= 1'b0;
        count    <= '0;
        wait_cnt <= '0;
      end else if (open && !close) begin
        wait_cnt <= wait_cnt + 1'b1;
      end
    end
  end

  // start index and outgoing request
  always_ff @(posedge clk) begin
    if (pop && (!open || close)) begin
      start_idx <= index;
    end
    if (emit) begin
      // index to byte address
      burst.addr <= offset + (start_idx << data_bytes_log);
      burst.len  <= axi_len_t'(count - 1'b1);
    end
  end

endmodule

`default_nettype wire

//--- logic/mmap_read.sv
`timescale 1ns/10ps
`default_nettype none

module mmap_read #(
  parameter int buffer_depth  = mmap_pkg::default_buffer_depth,
  parameter int max_wait_time = mmap_pkg::default_max_wait_time,
  parameter int max_burst_len = mmap_pkg::default_max_burst_len
) (
  input  logic                clk,
  input  logic                reset,

  // base of the memory region
  input  mmap_pkg::addr_t     offset,

  // user pushes element indices here
  input  mmap_pkg::addr_t     read_addr_din,
  input  logic                read_addr_write,
  output logic                read_addr_full_n,

  // user pops read data here
  output mmap_pkg::data_t     read_data_dout,
  input  logic                read_data_read,
  output logic                read_data_empty_n,

  // AR channel
  output logic                m_axi_arvalid,
  input  logic                m_axi_arready,
  output mmap_pkg::addr_t     m_axi_araddr,
  output axi_pkg::axi_len_t   m_axi_arlen,
  output axi_pkg::axi_size_t  m_axi_arsize,
  output axi_pkg::axi_burst_t m_axi_arburst,
  output axi_pkg::axi_cache_t m_axi_arcache,

  // R channel
  input  logic                m_axi_rvalid,
  output logic                m_axi_rready,
  input  mmap_pkg::data_t     m_axi_rdata
);

  import mmap_pkg::*;
  import axi_pkg::*;

  addr_t      index_head;
  logic       index_not_empty;
  logic       index_pop;

  burst_req_t burst_din;
  logic       burst_write;
  logic       burst_full_n;
  burst_req_t burst_head;
  logic       burst_not_empty;
  logic       burst_pop;

  logic       data_write;

  // index buffer, user to detector
  mmap_fifo #(
    .payload_t(addr_t),
    .depth    (buffer_depth)
  ) index_fifo (
    .clk      (clk),
    .reset    (reset),
    .din      (read_addr_din),
    .write    (read_addr_write),
    .full_n   (read_addr_full_n),
    .dout     (index_head),
    .read     (index_pop),
    .not_empty(index_not_empty)
  );

  burst_detector #(
    .max_wait_time(max_wait_time),
    .max_burst_len(max_burst_len)
  ) detector (
    .clk         (clk),
    .reset       (reset),
    .offset      (offset),
    .index       (index_head),
    .index_valid (index_not_empty),
    .pop         (index_pop),
    .burst       (burst_din),
    .burst_write (burst_write),
    .burst_full_n(burst_full_n)
  );

  // burst buffer, detector to AR channel
  mmap_fifo #(
    .payload_t(burst_req_t),
    .depth    (buffer_depth)
  ) burst_fifo (
    .clk      (clk),
    .reset    (reset),
    .din      (burst_din),
    .write    (burst_write),
    .full_n   (burst_full_n),
    .dout     (burst_head),
    .read     (burst_pop),
    .not_empty(burst_not_empty)
  );

  // data buffer, R channel to user
  mmap_fifo #(
    .payload_t(data_t),
    .depth    (buffer_depth)
  ) data_fifo (
    .clk      (clk),
    .reset    (reset),
    .din      (m_axi_rdata),
    .write    (data_write),
    .full_n   (m_axi_rready),
    .dout     (read_data_dout),
    .read     (read_data_read),
    .not_empty(read_data_empty_n)
  );

  // AR channel, head of the burst buffer held until accepted
  assign m_axi_arvalid = burst_not_empty;
  assign burst_pop     = m_axi_arvalid && m_axi_arready;
  assign m_axi_araddr  = burst_head.addr;
  assign m_axi_arlen   = burst_head.len;
  assign m_axi_arsize  = axi_size_t'(data_bytes_log);
  assign m_axi_arburst = burst_incr;
  assign m_axi_arcache = cache_modifiable;

  // R channel, one beat per accepted handshake
  assign data_write = m_axi_rvalid && m_axi_rready;

endmodule

`default_nettype wire

//--- test/axi_read_slave.sv
`timescale 1ns/10ps

module axi_read_slave #(
  parameter logic [31:0] seed = 32'd81566
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              arvalid,
  output logic              arready,
  input  mmap_pkg::addr_t   araddr,
  input  axi_pkg::axi_len_t arlen,
  output logic              rvalid,
  input  logic              rready,
  output mmap_pkg::addr_t   beat_addr
);

  import mmap_pkg::*;
  import axi_pkg::*;

  localparam addr_t bytes_per_word = addr_t'(data_width / 8);

  // accepted AR requests, served strictly in order
  addr_t       addr_q[$];
  axi_len_t    len_q[$];
  addr_t       cur_addr;
  int          beats_left;
  logic        active;
  logic [31:0] rng;

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  initial begin
    logic hold;
    arready    = 1'b0;
    rvalid     = 1'b0;
    beat_addr  = '0;
    cur_addr   = '0;
    beats_left = 0;
    active     = 1'b0;
    rng        = seed;
    forever begin
      @(posedge clk);
      if (reset) begin
        addr_q.delete();
        len_q.delete();
        active     = 1'b0;
        beats_left = 0;
        #1;
        arready = 1'b0;
        rvalid  = 1'b0;
      end else begin
        // a beat offered but not taken stays offered
        hold = rvalid && !rready;
        if (arvalid && arready) begin
          addr_q.push_back(araddr);
          len_q.push_back(arlen);
        end
        if (rvalid && rready) begin
          cur_addr   = cur_addr + bytes_per_word;
          beats_left = beats_left - 1;
          if (beats_left == 0) begin
            active = 1'b0;
          end
        end
        // next burst starts right after the last beat
        if (!active && addr_q.size() > 0) begin
          cur_addr   = addr_q.pop_front();
          beats_left = int'(len_q.pop_front()) + 1;
          active     = 1'b1;
        end
        rng = lcg_next(rng);
        #1;
        // roughly three out of four cycles ready or valid
        arready   = (rng[31:30] != 2'b00);
        rvalid    = active && (hold || (rng[28:27] != 2'b00));
        beat_addr = cur_addr;
      end
    end
  end

endmodule

//--- test/mmap_read_tb.sv
`timescale 1ns/10ps

module mmap_read_tb;

  import mmap_pkg::*;
  import axi_pkg::*;

  localparam int    buffer_depth   = 8;
  localparam int    max_wait_time  = 3;
  localparam int    max_burst_len  = 15;
  localparam int    timeout_cycles = 4000;
  localparam addr_t tb_offset      = 64'h0000_0000_8000_0040;
  localparam addr_t bytes_per_word = addr_t'(data_width / 8);

  logic       clk = 1'b0;
  logic       reset;
  addr_t      offset;
  addr_t      read_addr_din;
  logic       read_addr_write;
  logic       read_addr_full_n;
  data_t      read_data_dout;
  logic       read_data_read;
  logic       read_data_empty_n;
  logic       m_axi_arvalid;
  logic       m_axi_arready;
  addr_t      m_axi_araddr;
  axi_len_t   m_axi_arlen;
  axi_size_t  m_axi_arsize;
  axi_burst_t m_axi_arburst;
  axi_cache_t m_axi_arcache;
  logic       m_axi_rvalid;
  logic       m_axi_rready;
  data_t      m_axi_rdata;
  addr_t      beat_addr;

  // indices still owed a data word, and still owed an AR beat
  addr_t data_idx[$];
  addr_t ar_idx[$];
  int    data_errors = 0;
  int    ar_errors   = 0;
  int    misc_errors = 0;
  int    ar_count    = 0;
  int    ar_beats    = 0;
  int    data_words  = 0;
  logic  timed_out   = 1'b0;
  logic [31:0] rng = 32'd81566;

  always #20 clk = ~clk;

  mmap_read #(
    .buffer_depth (buffer_depth),
    .max_wait_time(max_wait_time),
    .max_burst_len(max_burst_len)
  ) dut_i (
    .clk(clk), .reset(reset), .offset(offset),
    .read_addr_din(read_addr_din), .read_addr_write(read_addr_write),
    .read_addr_full_n(read_addr_full_n),
    .read_data_dout(read_data_dout), .read_data_read(read_data_read),
    .read_data_empty_n(read_data_empty_n),
    .m_axi_arvalid(m_axi_arvalid), .m_axi_arready(m_axi_arready),
    .m_axi_araddr(m_axi_araddr), .m_axi_arlen(m_axi_arlen),
    .m_axi_arsize(m_axi_arsize), .m_axi_arburst(m_axi_arburst),
    .m_axi_arcache(m_axi_arcache),
    .m_axi_rvalid(m_axi_rvalid), .m_axi_rready(m_axi_rready), .m_axi_rdata(m_axi_rdata)
  );

  axi_read_slave #(.seed(32'd81566)) slave_i (
    .clk(clk), .reset(reset),
    .arvalid(m_axi_arvalid), .arready(m_axi_arready),
    .araddr(m_axi_araddr), .arlen(m_axi_arlen),
    .rvalid(m_axi_rvalid), .rready(m_axi_rready), .beat_addr(beat_addr)
  );

  // memory image where every lane mixes the full byte address
  function automatic data_t mem_word(input addr_t addr);
    data_t word;
    for (int i = 0; i < data_width / 64; i++) begin
      word[i*64 +: 64] = addr ^ (64'h9e37_79b9_7f4a_7c15 * 64'(i + 1));
    end
    return word;
  endfunction

  function automatic addr_t word_addr(input addr_t idx);
    return tb_offset + idx * bytes_per_word;
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  assign m_axi_rdata = mem_word(beat_addr);

  task automatic check_data(input data_t got, input data_t exp, input string what,
                            inout int errs);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
      errs++;
    end
  endtask

  task automatic check_addr(input addr_t got, input addr_t exp, input string what,
                            inout int errs);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
      errs++;
    end
  endtask

  task automatic check_len(input axi_len_t got, input axi_len_t exp, input string what,
                           inout int errs);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s got %0d expected %0d", $time, what, got, exp);
      errs++;
    end
  endtask

  // 64-byte beats, INCR bursts, bufferable and modifiable memory
  task automatic check_attr(input axi_size_t size, input axi_burst_t burst,
                            input axi_cache_t cache, inout int errs);
    if (size !== 3'd6 || burst !== 2'b01 || cache !== 4'b0011) begin
      $display("[ERROR] %0t: AR attributes size %0d burst %0d cache %0d", $time,
               size, burst, cache);
      errs++;
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what,
                            inout int errs);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s got %b expected %b", $time, what, got, exp);
      errs++;
    end
  endtask

  task automatic report_timeout(input string why);
    $display("timeout at %0t while %s", $time, why);
    timed_out = 1'b1;
  endtask

  // one index held until the buffer takes it
  task automatic push_index(input addr_t idx);
    int waited;
    waited = 0;
    if (!timed_out) begin
      read_addr_din   = idx;
      read_addr_write = 1'b1;
      @(posedge clk);
      while (!read_addr_full_n && waited < timeout_cycles) begin
        waited++;
        @(posedge clk);
      end
      if (!read_addr_full_n) begin
        report_timeout("pushing an index");
      end else begin
        data_idx.push_back(idx);
        ar_idx.push_back(idx);
      end
      #1;
      read_addr_write = 1'b0;
    end
  endtask

  task automatic wait_drained(input string what);
    int waited;
    waited = 0;
    if (!timed_out) begin
      do begin
        @(posedge clk);
        #1;
        waited++;
      end while ((data_idx.size() != 0 || ar_idx.size() != 0) && waited < timeout_cycles);
      if (data_idx.size() != 0 || ar_idx.size() != 0) begin
        report_timeout(what);
      end
    end
  endtask

  // compares popped words and AR requests against the index stream
  always @(posedge clk) begin : compare
    addr_t idx;
    int    beats;
    if (!reset) begin
      if (read_data_read && read_data_empty_n) begin
        data_words++;
        if (data_idx.size() == 0) begin
          $display("read data word popped at %0t with no index outstanding", $time);
          data_errors++;
        end else begin
          idx = data_idx.pop_front();
          check_data(read_data_dout, mem_word(word_addr(idx)), "read data", data_errors);
        end
      end
      if (m_axi_arvalid && m_axi_arready) begin
        ar_count++;
        beats    = int'(m_axi_arlen) + 1;
        ar_beats = ar_beats + beats;
        check_attr(m_axi_arsize, m_axi_arburst, m_axi_arcache, ar_errors);
        if (m_axi_arlen > axi_len_t'(max_burst_len)) begin
          $display("[ERROR] %0t: arlen %0d above limit %0d", $time, m_axi_arlen,
                   max_burst_len);
          ar_errors++;
        end
        if (ar_idx.size() < beats) begin
          $display("AR burst at %0t covers more beats than indices outstanding", $time);
          ar_errors++;
        end else begin
          for (int k = 0; k < beats; k++) begin
            idx = ar_idx.pop_front();
            check_addr(m_axi_araddr + addr_t'(k) * bytes_per_word, word_addr(idx),
                       "burst beat address", ar_errors);
          end
        end
      end
    end
  end

  initial begin
    addr_t start;
    int    count;
    int    step;
    int    before_beats;
    int    before_ars;
    int    before_words;
    int    waited;
    int    high_run;
    logic  saw_stall;
    reset           = 1'b1;
    offset          = tb_offset;
    read_addr_din   = '0;
    read_addr_write = 1'b0;
    read_data_read  = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;
    check_flag(m_axi_arvalid, 1'b0, "arvalid after reset", misc_errors);
    check_flag(read_data_empty_n, 1'b0, "read_data_empty_n after reset", misc_errors);
    check_flag(read_addr_full_n, 1'b1, "read_addr_full_n after reset", misc_errors);
    check_flag(m_axi_rready, 1'b1, "rready after reset", misc_errors);
    read_data_read = 1'b1;

    // random runs of consecutive or strided indices
    for (int run = 0; run < 8; run++) begin
      rng   = lcg_next(rng);
      start = addr_t'(rng[31:12]);
      rng   = lcg_next(rng);
      count = 1 + int'(rng[31:28]);
      rng   = lcg_next(rng);
      step  = rng[31] ? 1 : 2 + int'(rng[30:29]);
      for (int k = 0; k < count; k++) begin
        push_index(start + addr_t'(k * step));
      end
    end
    wait_drained("draining random runs");

    // sixteen consecutive indices back to back
    before_beats = ar_beats;
    before_ars   = ar_count;
    for (int k = 0; k < 16; k++) begin
      push_index(addr_t'(1000 + k));
    end
    wait_drained("draining the merged block");
    check_len(axi_len_t'(ar_beats - before_beats), axi_len_t'(16), "merged beats",
              misc_errors);
    // fewest bursts that can hold the block
    check_len(axi_len_t'(ar_count - before_ars),
              axi_len_t'((16 + max_burst_len) / (max_burst_len + 1)), "merged AR count",
              misc_errors);

    // lone index closed only by the wait counter
    before_ars   = ar_count;
    before_words = data_words;
    push_index(addr_t'(5000));
    wait_drained("draining the isolated index");
    check_len(axi_len_t'(ar_count - before_ars), axi_len_t'(1), "isolated AR count",
              misc_errors);
    check_len(axi_len_t'(data_words - before_words), axi_len_t'(1), "isolated words",
              misc_errors);

    // hold off the user side until the data buffer backs up
    read_data_read = 1'b0;
    for (int k = 0; k < 12; k++) begin
      push_index(addr_t'(7000 + k));
    end
    for (int k = 0; k < 8; k++) begin
      push_index(addr_t'(9000 + 3 * k));
    end
    waited    = 0;
    high_run  = 0;
    saw_stall = 1'b0;
    if (!timed_out) begin
      while ((high_run < 30 || !saw_stall) && waited < timeout_cycles) begin
        @(posedge clk);
        #1;
        waited++;
        high_run = read_data_empty_n ? high_run + 1 : 0;
        if (!m_axi_rready) begin
          saw_stall = 1'b1;
        end
      end
      if (high_run < 30 || !saw_stall) begin
        report_timeout("waiting for the data buffer to fill");
      end
    end
    read_data_read = 1'b1;
    wait_drained("draining after back-pressure");

    $display("errors: data %0d, address channel %0d, other %0d", data_errors, ar_errors,
             misc_errors);
    if (!timed_out && data_errors + ar_errors + misc_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- compile.f
logic/axi_pkg.sv
logic/mmap_pkg.sv
logic/mmap_fifo.sv
logic/burst_detector.sv
logic/mmap_read.sv
test/axi_read_slave.sv
test/mmap_read_tb.sv

//--- run.sh
#!/bin/sh
# build and run the mmap_read testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module mmap_read_tb -Mdir obj_dir -f compile.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

output=$(./obj_dir/Vmmap_read_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test completed successfully"; then
  exit 0
fi
exit 1
